// File: common/uart_macros.svh
/* UART build-time constants
   clock and line rates, bit time, FIFO depth and register map */

`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// system clock and line rate
`define UART_CLK_HZ 1_843_200
`define UART_BAUD 115_200

// clocks per serial bit
`define UART_BIT_TIME (`UART_CLK_HZ / `UART_BAUD)

// entries per FIFO, power of two only
`define UART_FIFO_DEPTH 4

// register offsets on the APB side
`define UART_ADDR_DATA 4'h0
`define UART_ADDR_STATUS 4'h4

`endif

// File: common/uart_pkg.sv
/* UART shared types
   APB request and response, receive entry and STATUS register layout */

package uart_pkg;

  // APB request, driven by the bus master
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // APB response, no PREADY since accesses have no wait states
  typedef struct packed {
    logic [31:0] prdata;
    logic        pslverr;
  } apb_rsp_t;

  // one received character
  typedef struct packed {
    logic       frame_err;  // stop bit sampled low
    logic [7:0] data;
  } rx_entry_t;

  /*
   * STATUS register, bit 0 is the last member
   * so the declaration runs from bit 5 down
   */
  typedef struct packed {
    logic rx_overrun;    // bit 5, sticky
    logic rx_frame_err;  // bit 4, head entry only
    logic rx_valid;      // bit 3
    logic tx_busy;       // bit 2
    logic tx_empty;      // bit 1
    logic tx_full;       // bit 0
  } uart_status_t;

endpackage

// File: hw/uart_fifo.sv
/* UART FIFO
   circular buffer with valid/ready push and pop, payload type set per instance */

`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push_valid,
  input  payload_t push_data,
  input  logic     pop_ready,
  output logic     pop_valid,
  output payload_t pop_data,
  output logic     full,
  output logic     empty
);

  localparam int Depth = `UART_FIFO_DEPTH;
  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  payload_t        mem [Depth];
  logic [PtrW-1:0] wr_ptr;
  logic [PtrW-1:0] rd_ptr;
  logic [CntW-1:0] count;
  logic            do_push;
  logic            do_pop;

  assign full      = (count == CntW'(Depth));
  assign empty     = (count == '0);
  assign pop_valid = !empty;
  assign pop_data  = mem[rd_ptr];  // head entry straight from storage flops

  assign do_push = push_valid && !full;  // push into a full FIFO is dropped
  assign do_pop  = pop_valid && pop_ready;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at the power-of-two depth
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      unique case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // both or neither leave the level as is
      endcase
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= CntW'(Depth))
    else $error("uart_fifo count %0d above depth", count);

endmodule

// File: hw/uart_apb_regs.sv
/* UART APB register block
   DATA and STATUS decode, FIFO strobes, read mux and slave error */

`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_apb_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_pkg::apb_req_t  apb_req,
  input  logic                tx_full,
  input  logic                tx_empty,
  input  logic                tx_busy,
  input  uart_pkg::rx_entry_t rx_head,
  input  logic                rx_valid,
  input  logic                rx_drop,
  output uart_pkg::apb_rsp_t  apb_rsp,
  output logic                tx_push,
  output logic [7:0]          tx_byte,
  output logic                rx_pop
);

  import uart_pkg::*;

  logic         access;
  logic         sel_data;
  logic         sel_status;
  logic         data_wr;
  logic         data_rd;
  logic         status_wr;
  logic         rx_overrun;
  uart_status_t status;

  // decode only in the access phase
  assign access     = apb_req.psel && apb_req.penable;
  assign sel_data   = (apb_req.paddr == `UART_ADDR_DATA);
  assign sel_status = (apb_req.paddr == `UART_ADDR_STATUS);

  assign data_wr   = access && sel_data && apb_req.pwrite;
  assign data_rd   = access && sel_data && !apb_req.pwrite;
  assign status_wr = access && sel_status && apb_req.pwrite;

  // FIFO strobes act at the edge closing the access phase
  assign tx_push = data_wr && !tx_full;
  assign tx_byte = apb_req.pwdata[7:0];
  assign rx_pop  = data_rd && rx_valid;

  always_comb begin
    status.tx_full      = tx_full;
    status.tx_empty     = tx_empty;
    status.tx_busy      = tx_busy;
    status.rx_valid     = rx_valid;
    status.rx_frame_err = rx_valid && rx_head.frame_err;  // only meaningful with a head entry
    status.rx_overrun   = rx_overrun;
  end

  always_comb begin
    apb_rsp.prdata = '0;
    if (sel_data) begin
      apb_rsp.prdata[8:0] = {rx_head.frame_err, rx_head.data};
    end else if (sel_status) begin
      apb_rsp.prdata[5:0] = status;
    end

    // full TX write, empty RX read, or a hole in the map
    apb_rsp.pslverr = access && ((data_wr && tx_full) ||
                                 (data_rd && !rx_valid) ||
                                 !(sel_data || sel_status));
  end

  // sticky overrun, a new drop wins over a clear in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_overrun <= 1'b0;
    end else if (rx_drop) begin
      rx_overrun <= 1'b1;
    end else if (status_wr && apb_req.pwdata[5]) begin
      rx_overrun <= 1'b0;
    end
  end

  // strobes only follow a proper setup phase and respect FIFO levels
  a_push_legal: assert property (@(posedge clk) disable iff (!rst_n)
    tx_push |-> !tx_full && $past(apb_req.psel && !apb_req.penable))
    else $error("tx_push without setup phase or into full FIFO");

  a_pop_legal: assert property (@(posedge clk) disable iff (!rst_n)
    rx_pop |-> rx_valid && $past(apb_req.psel && !apb_req.penable))
    else $error("rx_pop without setup phase or from empty FIFO");

endmodule

// File: uart_tx/uart_tx.sv
/* UART transmitter
   8N1 framing, pulls bytes from a valid/ready source, one bit per UART_BIT_TIME clocks */

`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       byte_valid,
  input  logic [7:0] byte_data,
  output logic       byte_ready,
  output logic       tx,
  output logic       busy
);

  localparam int BitTime = `UART_BIT_TIME;
  localparam int CntW = (BitTime > 1) ? $clog2(BitTime) : 1;

  typedef enum logic [1:0] {
    Idle,
    StartBit,
    DataBits,
    StopBit
  } state_e;

  state_e          state;
  logic [CntW-1:0] bit_timer;  // counts down to the last tick of a bit
  logic [2:0]      bit_idx;
  logic [7:0]      data_q;
  logic            bit_done;

  assign bit_done = (bit_timer == '0);

  // idle, or the last tick of a stop bit so frames run back to back
  assign byte_ready = (state == Idle) || ((state == StopBit) && bit_done);

  // byte held locally, FIFO is free to advance
  always_ff @(posedge clk) begin
    if (byte_valid && byte_ready) begin
      data_q <= byte_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= Idle;
      bit_timer <= '0;
      bit_idx   <= '0;
      tx        <= 1'b1;
      busy      <= 1'b0;
    end else begin
      unique case (state)
        Idle: begin
          if (byte_valid) begin
            tx        <= 1'b0;  // start bit begins at the acceptance edge
            busy      <= 1'b1;
            bit_timer <= CntW'(BitTime - 1);
            state     <= StartBit;
          end
        end

        StartBit: begin
          bit_timer <= bit_timer - 1'b1;
          if (bit_done) begin
            bit_timer <= CntW'(BitTime - 1);
            bit_idx   <= '0;
            tx        <= data_q[0];  // LSB first
            state     <= DataBits;
          end
        end

        DataBits: begin
          bit_timer <= bit_timer - 1'b1;
          if (bit_done) begin
            bit_timer <= CntW'(BitTime - 1);
            if (bit_idx == 3'd7) begin
              tx    <= 1'b1;  // stop bit
              state <= StopBit;
            end else begin
              bit_idx <= bit_idx + 3'd1;
              tx      <= data_q[bit_idx + 3'd1];
            end
          end
        end

        StopBit: begin
          bit_timer <= bit_timer - 1'b1;
          if (bit_done) begin
            if (byte_valid) begin
              tx        <= 1'b0;
              bit_timer <= CntW'(BitTime - 1);
              state     <= StartBit;
            end else begin
              busy  <= 1'b0;
              state <= Idle;
            end
          end
        end

        default: state <= Idle;
      endcase
    end
  end

  a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> tx)
    else $error("tx low while transmitter idle");

endmodule

// File: uart_rx/uart_rx.sv
/* UART receiver
   synchronizes the line, finds the start edge, samples mid-bit and checks the stop bit */

`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_rx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx,
  output logic                entry_valid,
  output uart_pkg::rx_entry_t entry
);

  localparam int BitTime = `UART_BIT_TIME;
  localparam int CntW = (BitTime > 1) ? $clog2(BitTime) : 1;
  localparam int HalfTime = (BitTime > 1) ? (BitTime / 2 - 1) : 0;

  typedef enum logic [1:0] {
    Idle,
    StartBit,
    DataBits,
    StopBit
  } state_e;

  state_e          state;
  logic            rx_meta;
  logic            rx_sync;
  logic            rx_prev;  // previous synced sample for edge detect
  logic [CntW-1:0] bit_timer;
  logic [2:0]      bit_idx;
  logic [7:0]      shift_q;
  logic            bit_done;

  assign bit_done = (bit_timer == '0);

  // two-flop synchronizer with the line idling high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= Idle;
      bit_timer   <= '0;
      bit_idx     <= '0;
      entry_valid <= 1'b0;
    end else begin
      entry_valid <= 1'b0;
      unique case (state)
        Idle: begin
          // start on a falling edge so a line held low after a bad stop bit is ignored
          if (rx_prev && !rx_sync) begin
            bit_timer <= CntW'(HalfTime);
            state     <= StartBit;
          end
        end

        StartBit: begin
          bit_timer <= bit_timer - 1'b1;
          if (bit_done) begin
            if (!rx_sync) begin
              bit_timer <= CntW'(BitTime - 1);
              bit_idx   <= '0;
              state     <= DataBits;
            end else begin
              state <= Idle;  // glitch
            end
          end
        end

        DataBits: begin
          bit_timer <= bit_timer - 1'b1;
          if (bit_done) begin
            bit_timer <= CntW'(BitTime - 1);
            bit_idx   <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) state <= StopBit;
          end
        end

        StopBit: begin
          bit_timer <= bit_timer - 1'b1;
          if (bit_done) begin
            entry_valid <= 1'b1;
            state       <= Idle;
          end
        end

        default: state <= Idle;
      endcase
    end
  end

  // mid-bit sample shifter and output entry
  always_ff @(posedge clk) begin
    if ((state == DataBits) && bit_done) begin
      shift_q <= {rx_sync, shift_q[7:1]};  // LSB arrives first
    end
    if ((state == StopBit) && bit_done) begin
      entry.data      <= shift_q;
      entry.frame_err <= !rx_sync;
    end
  end

endmodule

// File: hw/uart_top.sv
/* UART top level
   APB register block, TX and RX FIFOs, transmitter and receiver */

`timescale 1ns/1ps

module uart_top (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_pkg::apb_req_t apb_req,
  input  logic               rx,
  output uart_pkg::apb_rsp_t apb_rsp,
  output logic               tx
);

  import uart_pkg::*;

  logic       tx_push;
  logic [7:0] tx_byte;
  logic       tx_full;
  logic       tx_empty;
  logic       tx_busy;
  logic       tx_valid;  // TX FIFO head to transmitter
  logic       tx_ready;
  logic [7:0] tx_head;
  rx_entry_t  rx_entry;
  logic       rx_entry_valid;
  rx_entry_t  rx_head;
  logic       rx_valid;
  logic       rx_pop;
  logic       rx_full;
  logic       rx_drop;

  // character lost when the receive FIFO has no room
  assign rx_drop = rx_entry_valid && rx_full;

  uart_apb_regs u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .tx_full (tx_full),
    .tx_empty(tx_empty),
    .tx_busy (tx_busy),
    .rx_head (rx_head),
    .rx_valid(rx_valid),
    .rx_drop (rx_drop),
    .apb_rsp (apb_rsp),
    .tx_push (tx_push),
    .tx_byte (tx_byte),
    .rx_pop  (rx_pop)
  );

  uart_fifo #(.payload_t(logic [7:0])) u_tx_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_valid(tx_push),
    .push_data (tx_byte),
    .pop_ready (tx_ready),
    .pop_valid (tx_valid),
    .pop_data  (tx_head),
    .full      (tx_full),
    .empty     (tx_empty)
  );

  uart_fifo #(.payload_t(rx_entry_t)) u_rx_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_valid(rx_entry_valid),
    .push_data (rx_entry),
    .pop_ready (rx_pop),
    .pop_valid (rx_valid),
    .pop_data  (rx_head),
    .full      (rx_full),
    .empty     ()
  );

  uart_tx u_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .byte_valid(tx_valid),
    .byte_data (tx_head),
    .byte_ready(tx_ready),
    .tx        (tx),
    .busy      (tx_busy)
  );

  uart_rx u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .entry_valid(rx_entry_valid),
    .entry      (rx_entry)
  );

endmodule

// File: sim/tb_uart.sv
/* UART testbench
   APB driver, serial loopback with a bad-stop-bit injector, checking by assertions */

`timescale 1ns/1ps
`include "uart_macros.svh"

module tb_uart;

  import uart_pkg::*;

  localparam int BitTime = `UART_BIT_TIME;
  localparam int FrameTime = 10 * BitTime;
  localparam int PollLimit = 1000;  // STATUS polls per wait

  logic        clk;
  logic        rst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        tx;
  logic        rx_line;
  logic        inject;    // 1 selects the bit-banger instead of loopback
  logic        bb_line;
  logic        exp_err;
  logic        exp_chk;
  logic [31:0] exp_data;
  logic [31:0] lfsr;
  logic        tx_q;
  int unsigned since_start;  // clocks from the start-bit falling edge
  logic [7:0]  expect_q[$];

  assign rx_line = inject ? bb_line : tx;

  uart_top dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .apb_req(apb_req),
    .rx     (rx_line),
    .apb_rsp(apb_rsp),
    .tx     (tx)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b[i] = lfsr[0];  // one step per bit
    end
  endtask

  // STATUS word built from the register map, bit 0 upwards
  function automatic logic [31:0] status_bits(input logic full, input logic empty,
                                              input logic busy, input logic rxv,
                                              input logic ferr, input logic ovr);
    return {26'd0, ovr, ferr, rxv, busy, empty, full};
  endfunction

  // frame timing tracker for the tx line
  always @(posedge clk) begin
    tx_q <= tx;
    if (!rst_n) begin
      since_start <= FrameTime;
    end else if (tx_q && !tx && since_start >= FrameTime) begin
      since_start <= 1;  // start edge was one clock back
    end else if (since_start < FrameTime) begin
      since_start <= since_start + 1;
    end
  end

  a_pslverr: assert property (@(posedge clk) disable iff (!rst_n)
    apb_req.psel && apb_req.penable |-> apb_rsp.pslverr == exp_err)
    else stop_on_error($sformatf("ERROR pslverr got %h expected %h",
                                 $sampled(apb_rsp.pslverr), $sampled(exp_err)));

  a_prdata: assert property (@(posedge clk) disable iff (!rst_n)
    apb_req.psel && apb_req.penable && exp_chk |-> apb_rsp.prdata == exp_data)
    else stop_on_error($sformatf("ERROR prdata got %h expected %h",
                                 $sampled(apb_rsp.prdata), $sampled(exp_data)));

  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    !dut.tx_busy |-> tx)
    else stop_on_error($sformatf("ERROR tx got %h expected %h while idle", $sampled(tx), 1'b1));

  a_start_low: assert property (@(posedge clk) disable iff (!rst_n)
    since_start < BitTime |-> !tx)
    else stop_on_error("start bit on tx ended early");

  a_stop_high: assert property (@(posedge clk) disable iff (!rst_n)
    since_start >= 9 * BitTime && since_start < FrameTime |-> tx)
    else stop_on_error("stop bit on tx was not high for a full bit time");

  a_bit_grid: assert property (@(posedge clk) disable iff (!rst_n)
    tx != tx_q && since_start < FrameTime |-> since_start % BitTime == 0)
    else stop_on_error($sformatf("tx changed %0d clocks after the start edge, off the bit grid",
                                 $sampled(since_start)));

  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            input logic err, input logic chk, input logic [31:0] edata,
                            output logic [31:0] rdata);
    @(posedge clk);
    apb_req  <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    exp_err  <= err;
    exp_chk  <= chk && !wr;
    exp_data <= edata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    rdata = apb_rsp.prdata;  // mid access phase
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata, input logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, wdata, err, 1'b0, '0, unused);
  endtask

  task automatic apb_read_check(input logic [3:0] addr, input logic [31:0] edata,
                                input logic err);
    logic [31:0] unused;
    apb_access(1'b0, addr, '0, err, !err, edata, unused);
  endtask

  // poll STATUS until (word & mask) == want
  task automatic wait_status(input logic [31:0] mask, input logic [31:0] want, input string what);
    logic [31:0] st;
    int unsigned polls;
    polls = 0;
    apb_access(1'b0, `UART_ADDR_STATUS, '0, 1'b0, 1'b0, '0, st);
    while ((st & mask) != want) begin
      polls++;
      if (polls > PollLimit) begin
        stop_on_error($sformatf("timeout waiting for %s", what));
      end else begin
        apb_access(1'b0, `UART_ADDR_STATUS, '0, 1'b0, 1'b0, '0, st);
      end
    end
  endtask

  // 8 data bits, stop bit held low
  task automatic send_bad_frame(input logic [7:0] b);
    @(posedge clk);
    bb_line <= 1'b0;
    for (int i = 0; i < 8; i++) begin
      repeat (BitTime) @(posedge clk);
      bb_line <= b[i];
    end
    repeat (BitTime) @(posedge clk);
    bb_line <= 1'b0;
    repeat (BitTime) @(posedge clk);
    bb_line <= 1'b1;
  endtask

  initial begin
    logic [7:0] b;
    logic [7:0] sent[5];
    rst_n    = 1'b0;
    apb_req  = '0;
    inject   = 1'b0;
    bb_line  = 1'b1;
    exp_err  = 1'b0;
    exp_chk  = 1'b0;
    exp_data = '0;
    lfsr     = 32'h651d7869;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    apb_read_check(`UART_ADDR_STATUS, status_bits(0, 1, 0, 0, 0, 0), 1'b0);

    // loopback, four bytes back to back
    for (int i = 0; i < 4; i++) begin
      rand_byte(b);
      expect_q.push_back(b);
      apb_write(`UART_ADDR_DATA, {24'd0, b}, 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      wait_status(32'h08, 32'h08, "a received byte");
      apb_read_check(`UART_ADDR_DATA, {23'd0, 1'b0, expect_q.pop_front()}, 1'b0);
    end
    wait_status(32'h06, 32'h02, "the transmitter to go idle");

    // injected frame with a low stop bit
    @(posedge clk);
    inject <= 1'b1;
    rand_byte(b);
    send_bad_frame(b);
    wait_status(32'h08, 32'h08, "the injected byte");
    apb_read_check(`UART_ADDR_STATUS, status_bits(0, 1, 0, 1, 1, 0), 1'b0);
    apb_read_check(`UART_ADDR_DATA, {23'd0, 1'b1, b}, 1'b0);
    @(posedge clk);
    inject <= 1'b0;

    // one byte in the transmitter plus four queued fills the FIFO
    for (int i = 0; i < 5; i++) begin
      rand_byte(sent[i]);
      apb_write(`UART_ADDR_DATA, {24'd0, sent[i]}, 1'b0);
    end
    apb_read_check(`UART_ADDR_STATUS, status_bits(1, 0, 1, 0, 0, 0), 1'b0);
    apb_write(`UART_ADDR_DATA, 32'h0000_00a5, 1'b1);  // rejected, FIFO full

    // fifth frame lands in a full receive FIFO
    wait_status(32'h06, 32'h02, "all five frames to leave");
    apb_read_check(`UART_ADDR_STATUS, status_bits(0, 1, 0, 1, 0, 1), 1'b0);
    for (int i = 0; i < 4; i++) begin
      apb_read_check(`UART_ADDR_DATA, {23'd0, 1'b0, sent[i]}, 1'b0);
    end
    apb_read_check(`UART_ADDR_DATA, '0, 1'b1);  // nothing left to read
    apb_read_check(4'h8, '0, 1'b1);
    apb_write(`UART_ADDR_STATUS, 32'h0000_0020, 1'b0);
    apb_read_check(`UART_ADDR_STATUS, status_bits(0, 1, 0, 0, 0, 0), 1'b0);

    repeat (4) @(posedge clk);
    $display("Test OK");
    $finish;
  end

endmodule

// File: build.f
+incdir+common
common/uart_pkg.sv
hw/uart_fifo.sv
hw/uart_apb_regs.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
hw/uart_top.sv
sim/tb_uart.sv

// File: run_sim.sh
#!/bin/sh
# build the UART testbench with Verilator, run it and check its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f build.f \
  --top-module tb_uart &&
  ./obj_dir/Vtb_uart | tee /dev/stderr | grep -x "Test OK" > /dev/null &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
